// ==== include/elink_params.svh ====
// Link parameters for the eLink receive path
// Include this header wherever the link ID, response group or burst step
// is needed. Override a macro before the include to retarget the link.

`ifndef ELINK_PARAMS_SVH
`define ELINK_PARAMS_SVH

// ID of this link, compared with dstaddr[31:20]
`define ELINK_ID 12'h999

// Group code in dstaddr[19:16] that marks a read response
`define ELINK_GROUP_RR 4'hE

// Address step between consecutive burst packets
// Each burst packet carries one doubleword
`define ELINK_BURST_STEP 32'd8

`endif

// ==== rtl/elink_pkg.sv ====
// Shared types for the eLink receive path
// Modules import this package in their body and use scoped names on ports

`default_nettype none

package elink_pkg;

   // Address and data words
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;

   // Control field, write bit plus data and control modes
   typedef logic [6:0] ctrl_t;

   // One beat from the link deserializer
   typedef logic [63:0] link_word_t;

   // Transaction packet, 104 bits
   // Access sits in bit 0, srcaddr in the top word
   typedef struct packed {
      addr_t srcaddr;
      data_t data;
      addr_t dstaddr;
      ctrl_t ctrl;
      logic  access;
   } elink_packet_t;

   // Framer states
   typedef enum logic [1:0] {
      FR_IDLE,
      FR_HEAD_DONE,
      FR_BURST
   } frame_state_t;

endpackage

`default_nettype wire

// ==== rtl/erx_frame.sv ====
// Receive framer for the eLink
// Turns 64-bit link beats into transaction packets. The first packet of a
// frame takes a header beat and a data beat; every later beat in the same
// frame is a burst packet that reuses the header's ctrl.
// rx_access pulses one cycle after the packet's last beat.

`timescale 1ns/1ns
`default_nettype none

module erx_frame (
   input  wire logic                    clk,
   input  wire logic                    arst_n,
   input  wire logic                    link_frame,
   input  wire elink_pkg::link_word_t   link_word,
   output logic                         rx_access,
   output logic                         rx_burst,
   output elink_pkg::elink_packet_t     rx_packet
);

   import elink_pkg::*;

   frame_state_t state;

   // Header fields held for the rest of the frame
   addr_t hdr_dstaddr;
   ctrl_t hdr_ctrl;

   logic head_beat;
   logic pkt_beat;
   logic burst_beat;

   // Beat classification
   // Header only in idle, any later beat completes a packet
   assign head_beat  = link_frame && (state == FR_IDLE);
   assign pkt_beat   = link_frame && (state != FR_IDLE);
   assign burst_beat = link_frame && (state == FR_BURST);

   // State and strobes
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= FR_IDLE;
         rx_access <= 1'b0;
         rx_burst  <= 1'b0;
      end
      else
      begin
         rx_access <= pkt_beat;
         rx_burst  <= burst_beat;
         case (state)
            FR_IDLE:
            begin
               if (link_frame)
                  state <= FR_HEAD_DONE;
            end
            FR_HEAD_DONE:
            begin
               // Lone header with frame dropped gives nothing
               if (link_frame)
                  state <= FR_BURST;
               else
                  state <= FR_IDLE;
            end
            FR_BURST:
            begin
               if (!link_frame)
                  state <= FR_IDLE;
            end
            default:
               state <= FR_IDLE;
         endcase
      end
   end

   // Packet assembly
   always_ff @(posedge clk)
   begin
      // Header beat, dstaddr high word and ctrl in 30:24
      if (head_beat)
      begin
         hdr_dstaddr <= link_word[63:32];
         hdr_ctrl    <= link_word[30:24];
      end
      // Data beat, data high word and srcaddr low word
      if (pkt_beat)
      begin
         rx_packet.srcaddr <= link_word[31:0];
         rx_packet.data    <= link_word[63:32];
         // Burst packets leave address generation downstream
         rx_packet.dstaddr <= burst_beat ? '0 : hdr_dstaddr;
         rx_packet.ctrl    <= hdr_ctrl;
         rx_packet.access  <= 1'b1;
      end
   end

   // A burst packet is always part of a run of back-to-back packets
   assert property (@(posedge clk) disable iff (!arst_n)
      rx_burst |-> rx_access && $past(rx_access))
   else $error("rx_burst without a preceding packet");

endmodule

`default_nettype wire

// ==== rtl/erx_protocol.sv ====
// Protocol stage of the eLink receive path
// Generates burst destination addresses, flags read responses to this
// link and decodes each packet into one of three strobes.
// Strobes and out_packet follow rx_access by one cycle.

`timescale 1ns/1ns
`default_nettype none

`include "elink_params.svh"

module erx_protocol (
   input  wire logic                    clk,
   input  wire logic                    arst_n,
   input  wire logic                    test_mode,
   input  wire logic                    rx_access,
   input  wire logic                    rx_burst,
   input  wire elink_pkg::elink_packet_t rx_packet,
   output logic                         rdwr_access,
   output logic                         rr_access,
   output logic                         test_access,
   output elink_pkg::elink_packet_t     out_packet,
   output elink_pkg::data_t             test_data
);

   import elink_pkg::*;

   addr_t dstaddr_reg;
   addr_t dstaddr_mux;
   logic  read_response;

   // Burst address, previous plus one step
   assign dstaddr_mux = rx_burst ? dstaddr_reg + `ELINK_BURST_STEP
                                 : rx_packet.dstaddr;

   always_ff @(posedge clk)
   begin
      if (rx_access)
         dstaddr_reg <= dstaddr_mux;
   end

   // Read response to our ID
   // Uses generated address so bursts are checked too
   assign read_response = (dstaddr_mux[31:20] == `ELINK_ID) &&
                          (dstaddr_mux[19:16] == `ELINK_GROUP_RR);

   // Decode stage
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rdwr_access <= 1'b0;
         rr_access   <= 1'b0;
         test_access <= 1'b0;
      end
      else
      begin
         rdwr_access <= !test_mode && rx_access && !read_response;
         rr_access   <= !test_mode && rx_access && read_response;
         // Read responses dropped in test mode
         test_access <= test_mode && rx_access && !read_response;
      end
   end

   // Packet stage, access bit cleared on the way out
   always_ff @(posedge clk)
   begin
      if (rx_access)
      begin
         out_packet.srcaddr <= rx_packet.srcaddr;
         out_packet.data    <= rx_packet.data;
         out_packet.dstaddr <= dstaddr_mux;
         out_packet.ctrl    <= rx_packet.ctrl;
         out_packet.access  <= 1'b0;
      end
   end

   assign test_data = out_packet.data;

   // Strobes are exclusive
   assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0({rdwr_access, rr_access, test_access}))
   else $error("More than one protocol strobe high");

   // Every strobe traces back to a packet from the framer
   assert property (@(posedge clk) disable iff (!arst_n)
      (rdwr_access || rr_access || test_access) |-> $past(rx_access))
   else $error("Protocol strobe without rx_access");

endmodule

`default_nettype wire

// ==== rtl/erx_test_monitor.sv ====
// Test-mode monitor for the eLink receive path
// Folds each test packet's data into a rotate-XOR signature and counts
// test packets. Both clear on the cycle test_mode rises.

`timescale 1ns/1ns
`default_nettype none

module erx_test_monitor (
   input  wire logic                clk,
   input  wire logic                arst_n,
   input  wire logic                test_mode,
   input  wire logic                test_access,
   input  wire elink_pkg::data_t    test_data,
   output elink_pkg::data_t         test_signature,
   output logic [15:0]              test_count
);

   import elink_pkg::*;

   logic test_mode_q;
   logic mode_rise;

   // Edge detect on test_mode
   assign mode_rise = test_mode && !test_mode_q;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         test_mode_q    <= 1'b0;
         test_signature <= '0;
         test_count     <= '0;
      end
      else
      begin
         test_mode_q <= test_mode;
         if (mode_rise)
         begin
            // New test run
            test_signature <= '0;
            test_count     <= '0;
         end
         else if (test_access)
         begin
            // Rotate left by one, then fold in data
            test_signature <= {test_signature[30:0], test_signature[31]} ^ test_data;
            test_count     <= test_count + 16'd1;
         end
      end
   end

   // Test packets are decoded upstream with test mode already on
   assert property (@(posedge clk) disable iff (!arst_n)
      test_access |-> test_mode_q)
   else $error("test_access while test mode was off");

endmodule

`default_nettype wire

// ==== rtl/erx_top.sv ====
// Top of the eLink receive path
// Link beats go through the framer, then the protocol decode.
// Test-mode traffic also feeds the signature monitor.

`timescale 1ns/1ns
`default_nettype none

module erx_top (
   input  wire logic                    clk,
   input  wire logic                    arst_n,
   input  wire logic                    test_mode,
   input  wire logic                    link_frame,
   input  wire elink_pkg::link_word_t   link_word,
   output logic                         rdwr_access,
   output logic                         rr_access,
   output logic                         test_access,
   output elink_pkg::elink_packet_t     out_packet,
   output elink_pkg::data_t             test_signature,
   output logic [15:0]                  test_count
);

   import elink_pkg::*;

   // Framer to protocol
   logic          rx_access;
   logic          rx_burst;
   elink_packet_t rx_packet;

   // Protocol to monitor
   data_t test_data;

   erx_frame u_frame (
      .clk        (clk),
      .arst_n     (arst_n),
      .link_frame (link_frame),
      .link_word  (link_word),
      .rx_access  (rx_access),
      .rx_burst   (rx_burst),
      .rx_packet  (rx_packet)
   );

   erx_protocol u_protocol (
      .clk         (clk),
      .arst_n      (arst_n),
      .test_mode   (test_mode),
      .rx_access   (rx_access),
      .rx_burst    (rx_burst),
      .rx_packet   (rx_packet),
      .rdwr_access (rdwr_access),
      .rr_access   (rr_access),
      .test_access (test_access),
      .out_packet  (out_packet),
      .test_data   (test_data)
   );

   erx_test_monitor u_test_monitor (
      .clk            (clk),
      .arst_n         (arst_n),
      .test_mode      (test_mode),
      .test_access    (test_access),
      .test_data      (test_data),
      .test_signature (test_signature),
      .test_count     (test_count)
   );

endmodule

`default_nettype wire

// ==== tests/tb_clkgen.sv ====
// Clock and reset source for the eLink receive testbench
// 20 ns clock; arst_n held low for 8 rising edges, then released
// just after an edge so it never races the DUT's clocked logic

`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
   output logic clk,
   output logic arst_n
);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Reset for 8 cycles
   initial
   begin
      arst_n = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== tests/erx_tb.sv ====
// Testbench for the eLink receive path
// Drives link beats into erx_top and predicts every strobe and
// out_packet with a small model, two cycles ahead of the DUT.
// Concurrent assertions compare every cycle and each test prints one line.

`timescale 1ns/1ns
`default_nettype none

`include "elink_params.svh"

module erx_tb;

   import elink_pkg::*;

   // Expected DUT response for one drive cycle
   typedef struct packed {
      logic          rdwr;
      logic          rr;
      logic          test;
      logic          pkt_valid;
      elink_packet_t pkt;
   } expect_t;

   logic          clk;
   logic          arst_n;
   logic          test_mode;
   logic          link_frame;
   link_word_t    link_word;
   logic          rdwr_access;
   logic          rr_access;
   logic          test_access;
   elink_packet_t out_packet;
   data_t         test_signature;
   logic [15:0]   test_count;

   expect_t     exp_now;
   expect_t     exp_d1;
   expect_t     exp_d2;
   logic [31:0] lfsr;
   addr_t       model_addr;
   // Data of packets that should reach the monitor
   data_t       test_q[$];
   int          exp_strobes = 0;
   int          seen_strobes = 0;
   int          errors = 0;
   int          errors_at_start = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   tb_clkgen u_clkgen (.clk(clk), .arst_n(arst_n));

   erx_top DUT (
      .clk            (clk),
      .arst_n         (arst_n),
      .test_mode      (test_mode),
      .link_frame     (link_frame),
      .link_word      (link_word),
      .rdwr_access    (rdwr_access),
      .rr_access      (rr_access),
      .test_access    (test_access),
      .out_packet     (out_packet),
      .test_signature (test_signature),
      .test_count     (test_count)
   );

   // Delay line matching the two-cycle DUT latency
   always @(posedge clk)
   begin
      exp_d1 <= exp_now;
      exp_d2 <= exp_d1;
      if (arst_n && (rdwr_access || rr_access || test_access))
         seen_strobes <= seen_strobes + 1;
   end

   // Strobes checked every cycle including idle ones
   assert property (@(posedge clk) disable iff (!arst_n)
      {rdwr_access, rr_access, test_access} == {exp_d2.rdwr, exp_d2.rr, exp_d2.test})
   else
   begin
      $display("ERROR {rdwr_access,rr_access,test_access}: got %h expected %h",
         $sampled({rdwr_access, rr_access, test_access}),
         $sampled({exp_d2.rdwr, exp_d2.rr, exp_d2.test}));
      errors++;
   end

   // All packet fields including dropped responses
   assert property (@(posedge clk) disable iff (!arst_n)
      exp_d2.pkt_valid |-> out_packet == exp_d2.pkt)
   else
   begin
      $display("ERROR out_packet: got %h expected %h",
         $sampled(out_packet), $sampled(exp_d2.pkt));
      errors++;
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        bit_out;
      int          i;
      val = '0;
      for (i = 0; i < n; i++)
      begin
         bit_out = lfsr[0];
         lfsr = lfsr >> 1;
         if (bit_out)
            lfsr = lfsr ^ 32'hB4BC_D35C;
         val = {val[30:0], bit_out};
      end
      return val;
   endfunction

   // Random address kept out of the read-response group
   function automatic addr_t plain_addr();
      addr_t a;
      a = rand_bits(32);
      if (a[31:20] == `ELINK_ID && a[19:16] == `ELINK_GROUP_RR)
         a[16] = ~a[16];
      return a;
   endfunction

   // Model of burst address and decode for one packet
   function automatic expect_t model_packet(input logic burst, input addr_t hdr,
                                            input ctrl_t ctrl, input data_t data,
                                            input addr_t src);
      expect_t e;
      logic    resp;
      model_addr = burst ? model_addr + `ELINK_BURST_STEP : hdr;
      resp = model_addr[31:20] == `ELINK_ID && model_addr[19:16] == `ELINK_GROUP_RR;
      e = '0;
      e.pkt_valid   = 1'b1;
      e.pkt.srcaddr = src;
      e.pkt.data    = data;
      e.pkt.dstaddr = model_addr;
      e.pkt.ctrl    = ctrl;
      e.rdwr = !test_mode && !resp;
      e.rr   = !test_mode && resp;
      // Responses vanish in test mode
      e.test = test_mode && !resp;
      if (e.rdwr || e.rr || e.test)
         exp_strobes++;
      if (e.test)
         test_q.push_back(data);
      return e;
   endfunction

   task automatic drive_beat(input logic frame, input link_word_t word, input expect_t e);
      @(posedge clk);
      #2;
      link_frame = frame;
      link_word  = word;
      exp_now    = e;
   endtask

   // Header beat and n packets, then one idle beat closes the frame
   task automatic send_frame(input addr_t dst, input int n_pkts);
      ctrl_t ctrl;
      data_t data;
      addr_t src;
      int    i;
      ctrl = ctrl_t'(rand_bits(7));
      drive_beat(1'b1, {dst, 1'b0, ctrl, 24'h0}, '0);
      for (i = 0; i < n_pkts; i++)
      begin
         data = rand_bits(32);
         src  = rand_bits(32);
         drive_beat(1'b1, {data, src}, model_packet(i > 0, dst, ctrl, data, src));
      end
      drive_beat(1'b0, '0, '0);
   endtask

   task automatic wait_strobes();
      int cycles;
      cycles = 0;
      while (seen_strobes < exp_strobes && cycles < 50)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (seen_strobes < exp_strobes)
      begin
         $display("Timed out waiting for strobes, saw %0d of %0d", seen_strobes, exp_strobes);
         errors++;
      end
   endtask

   task automatic check_quiet();
      assert (!rdwr_access && !rr_access && !test_access)
      else
      begin
         $display("ERROR {rdwr_access,rr_access,test_access}: got %h expected 0",
            {rdwr_access, rr_access, test_access});
         errors++;
      end
      assert (test_signature == '0 && test_count == '0)
      else
      begin
         $display("ERROR test_signature/test_count: got %h/%h expected 0/0",
            test_signature, test_count);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == errors_at_start)
         $display("test %0d %s: ok", tests_run, name);
      else
      begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   initial
   begin
      int    cycles;
      int    i;
      data_t sig;
      lfsr       = 32'd83;
      model_addr = '0;
      test_mode  = 1'b0;
      link_frame = 1'b0;
      link_word  = '0;
      exp_now    = '0;

      // Test 1 checks outputs in and after reset
      repeat (3) @(posedge clk);
      #1;
      check_quiet();
      cycles = 0;
      while (!arst_n && cycles < 20)
      begin
         @(posedge clk);
         cycles++;
      end
      if (!arst_n)
      begin
         $display("Reset was never released");
         errors++;
      end
      repeat (2) @(posedge clk);
      #1;
      check_quiet();
      end_test("reset");

      // Test 2 sends plain read/write packets
      for (i = 0; i < 6; i++)
         send_frame(plain_addr(), 1);
      wait_strobes();
      end_test("single packets");

      // Test 3 sends responses to this link
      for (i = 0; i < 4; i++)
         send_frame({`ELINK_ID, `ELINK_GROUP_RR, 16'h0} | rand_bits(16), 1);
      wait_strobes();
      end_test("read responses");

      // Test 4 sends bursts of 2 to 6 packets
      for (i = 0; i < 3; i++)
         send_frame(plain_addr(), 2 + int'(rand_bits(3) % 5));
      wait_strobes();
      end_test("bursts");

      // Test mode with one response in the middle
      drive_beat(1'b0, '0, '0);
      test_mode = 1'b1;
      test_q.delete();
      repeat (2) drive_beat(1'b0, '0, '0);
      for (i = 0; i < 4; i++)
         send_frame(plain_addr(), 1);
      send_frame({`ELINK_ID, `ELINK_GROUP_RR, 16'h0} | rand_bits(16), 1);
      send_frame(plain_addr(), 3);
      wait_strobes();
      // Monitor lags the last strobe by one cycle
      cycles = 0;
      while (test_count != 16'(test_q.size()) && cycles < 20)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      // Expected signature folded over the sent test data
      sig = '0;
      foreach (test_q[k])
         sig = {sig[30:0], sig[31]} ^ test_q[k];
      assert (test_count == 16'(test_q.size()))
      else
      begin
         $display("ERROR test_count: got %h expected %h", test_count, 16'(test_q.size()));
         errors++;
      end
      assert (test_signature == sig)
      else
      begin
         $display("ERROR test_signature: got %h expected %h", test_signature, sig);
         errors++;
      end
      end_test("test mode");

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
rtl/elink_pkg.sv
rtl/erx_frame.sv
rtl/erx_protocol.sv
rtl/erx_test_monitor.sv
rtl/erx_top.sv
tests/tb_clkgen.sv
tests/erx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the eLink receive testbench with Verilator

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f flist.f --top-module erx_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Verx_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q -F "*** TEST FAILED ***" sim.log; then
   exit 1
fi
exit 0
